// ==== mac_cluster.f ====
+incdir+rtl
rtl/mac_cmd_pkg.sv
rtl/mac_dp_pkg.sv
rtl/mac_datapath.sv
rtl/mac_channel_ctrl.sv
rtl/mac_arbiter.sv
rtl/mac_cluster_top.sv
verif/mac_cluster_assertions.sv
verif/mac_cluster_tb.sv

// ==== rtl/mac_arbiter.sv ====
`timescale 1ns/10ps
`include "mac_params.svh"

module mac_arbiter
	import mac_dp_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      dp_req0,
	input  logic                      dp_req1,
	input  logic                      op_valid0,
	input  mul_src_e                  mul_src0,
	input  add_src_e                  add_src0,
	input  logic [`MAC_OPERAND_W-1:0] multiplicand0,
	input  logic [`MAC_OPERAND_W-1:0] multiplier0,
	input  logic [`MAC_OPERAND_W-1:0] addend0,
	input  logic                      op_valid1,
	input  mul_src_e                  mul_src1,
	input  add_src_e                  add_src1,
	input  logic [`MAC_OPERAND_W-1:0] multiplicand1,
	input  logic [`MAC_OPERAND_W-1:0] multiplier1,
	input  logic [`MAC_OPERAND_W-1:0] addend1,
	output logic                      dp_ack0,
	output logic                      dp_ack1,
	output logic                      op_valid,
	output mul_src_e                  mul_src,
	output add_src_e                  add_src,
	output logic [`MAC_OPERAND_W-1:0] multiplicand,
	output logic [`MAC_OPERAND_W-1:0] multiplier,
	output logic [`MAC_OPERAND_W-1:0] addend
);

	// One-hot grant, bit 0 for channel 0 and bit 1 for channel 1
	logic [1:0] grant;
	// Channel that held the datapath most recently
	logic       last_served;

	assign dp_ack0 = grant[0];
	assign dp_ack1 = grant[1];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			grant <= 2'b00;
			// Channel 0 wins the first contended grant
			last_served <= 1'b1;
		end else if (grant == 2'b00) begin
			// On contention the channel not served last goes first
			if (dp_req0 && (!dp_req1 || last_served)) begin
				grant <= 2'b01;
				last_served <= 1'b0;
			end else if (dp_req1) begin
				grant <= 2'b10;
				last_served <= 1'b1;
			end
		end else if ((grant[0] && !dp_req0) || (grant[1] && !dp_req1)) begin
			// The owner has let go; the idle cycle after this keeps grants apart
			grant <= 2'b00;
		end
	end

	// An issue from the channel without the grant never reaches the datapath
	assign op_valid = (grant[0] && op_valid0) || (grant[1] && op_valid1);

	assign mul_src = grant[1] ? mul_src1 : mul_src0;
	assign add_src = grant[1] ? add_src1 : add_src0;
	assign multiplicand = grant[1] ? multiplicand1 : multiplicand0;
	assign multiplier = grant[1] ? multiplier1 : multiplier0;
	assign addend = grant[1] ? addend1 : addend0;

endmodule

// ==== rtl/mac_channel_ctrl.sv ====
`timescale 1ns/10ps
`include "mac_params.svh"

module mac_channel_ctrl
	import mac_cmd_pkg::*, mac_dp_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      req,
	input  mac_mode_e                 mode,
	input  logic                      last,
	input  mac_cmd_u                  word,
	input  logic                      dp_ack,
	input  logic [`MAC_RESULT_W-1:0]  result,
	input  logic                      result_valid,
	output logic                      ack,
	output logic                      res_valid,
	output logic [`MAC_RESULT_W-1:0]  res,
	output logic                      dp_req,
	output logic                      op_valid,
	output mul_src_e                  mul_src,
	output add_src_e                  add_src,
	output logic [`MAC_OPERAND_W-1:0] multiplicand,
	output logic [`MAC_OPERAND_W-1:0] multiplier,
	output logic [`MAC_OPERAND_W-1:0] addend
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_WAIT_GRANT,
		ST_TRI_FIRST,
		ST_TRI_SECOND,
		ST_SOP_RUN,
		ST_SOP_DRAIN,
		ST_RELEASE
	} state_e;

	state_e                   state;
	state_e                   state_next;
	logic                     ack_q;
	logic                     start;
	logic                     host_issue;
	mac_cmd_u                 word_q;
	logic [`MAC_RESULT_W-1:0] res_q;

	// The grant arrives while waiting, and the first operation goes out at once
	assign start = (state == ST_WAIT_GRANT) && dp_ack;
	// A new element is a req whose ack has not been given yet
	assign host_issue = start || ((state == ST_SOP_RUN) && req && !ack_q);
	// Ack rises in the issue cycle and holds until the host drops req
	assign ack = ack_q || host_issue;

	// The datapath stays claimed from the request until the result pulse
	assign dp_req = (state != ST_IDLE) && (state != ST_RELEASE);

	// Only the final result of a trinomial or a burst goes to the host
	// Elements of a burst are spaced by the four-phase handshake, so all earlier
	// elements have retired by the time the drain state waits
	assign res_valid = result_valid && ((state == ST_TRI_SECOND) || (state == ST_SOP_DRAIN));
	assign res = res_valid ? result : res_q;

	always_comb begin
		op_valid = 1'b0;
		mul_src = MUL_SRC_OPERAND;
		add_src = ADD_SRC_OPERAND;
		multiplicand = word.sop.a;
		multiplier = word.sop.x;
		addend = '0;
		case (state)
			ST_WAIT_GRANT: begin
				// First trinomial step a*x + b, or the first burst element a*x + 0
				if (dp_ack) begin
					op_valid = 1'b1;
					if (mode == MODE_TRI) begin
						multiplicand = word.trin.a;
						multiplier = word.trin.x;
						addend = word.trin.b;
					end
				end
			end
			ST_TRI_FIRST: begin
				// Second step r*x + c starts as r leaves the pipeline
				// The host may have moved on, so x and c come from the saved word
				if (result_valid) begin
					op_valid = 1'b1;
					mul_src = MUL_SRC_RESULT;
					multiplicand = word_q.trin.a;
					multiplier = word_q.trin.x;
					addend = word_q.trin.c;
				end
			end
			ST_SOP_RUN: begin
				// Later burst elements add into the running sum
				if (req && !ack_q) begin
					op_valid = 1'b1;
					add_src = ADD_SRC_ACCUM;
				end
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (req && !ack_q)
					state_next = ST_WAIT_GRANT;
			end
			ST_WAIT_GRANT: begin
				if (dp_ack) begin
					if (mode == MODE_TRI)
						state_next = ST_TRI_FIRST;
					else
						state_next = last ? ST_SOP_DRAIN : ST_SOP_RUN;
				end
			end
			ST_TRI_FIRST: begin
				if (result_valid)
					state_next = ST_TRI_SECOND;
			end
			ST_TRI_SECOND: begin
				if (result_valid)
					state_next = ST_RELEASE;
			end
			ST_SOP_RUN: begin
				if (req && !ack_q && last)
					state_next = ST_SOP_DRAIN;
			end
			ST_SOP_DRAIN: begin
				if (result_valid)
					state_next = ST_RELEASE;
			end
			// Hold until the arbiter has taken the grant back
			ST_RELEASE: begin
				if (!dp_ack)
					state_next = ST_IDLE;
			end
			default: begin
				state_next = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ST_IDLE;
			ack_q <= 1'b0;
		end else begin
			state <= state_next;
			if (host_issue)
				ack_q <= 1'b1;
			else if (!req)
				ack_q <= 1'b0;
		end
	end

	// Trinomial operands and the last result shown to the host
	always_ff @(posedge clk) begin
		if (start)
			word_q <= word;
		if (res_valid)
			res_q <= result;
	end

endmodule

// ==== rtl/mac_cluster_top.sv ====
`timescale 1ns/10ps
`include "mac_params.svh"

module mac_cluster_top
	import mac_cmd_pkg::*, mac_dp_pkg::*;
(
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     ch0_req,
	input  mac_mode_e                ch0_mode,
	input  logic                     ch0_last,
	input  mac_cmd_u                 ch0_word,
	output logic                     ch0_ack,
	output logic                     ch0_res_valid,
	output logic [`MAC_RESULT_W-1:0] ch0_res,
	input  logic                     ch1_req,
	input  mac_mode_e                ch1_mode,
	input  logic                     ch1_last,
	input  mac_cmd_u                 ch1_word,
	output logic                     ch1_ack,
	output logic                     ch1_res_valid,
	output logic [`MAC_RESULT_W-1:0] ch1_res
);

	// Controller side of each channel's link to the arbiter
	logic                      dp_req0, dp_req1;
	logic                      dp_ack0, dp_ack1;
	logic                      op_valid0, op_valid1;
	mul_src_e                  mul_src0, mul_src1;
	add_src_e                  add_src0, add_src1;
	logic [`MAC_OPERAND_W-1:0] multiplicand0, multiplicand1;
	logic [`MAC_OPERAND_W-1:0] multiplier0, multiplier1;
	logic [`MAC_OPERAND_W-1:0] addend0, addend1;

	// Controls of the granted channel, and the result broadcast to both
	logic                      dp_op_valid;
	mul_src_e                  dp_mul_src;
	add_src_e                  dp_add_src;
	logic [`MAC_OPERAND_W-1:0] dp_multiplicand, dp_multiplier, dp_addend;
	logic [`MAC_RESULT_W-1:0]  result;
	logic                      result_valid;

	mac_channel_ctrl ch0 (
		.clk(clk), .reset(reset), .req(ch0_req), .mode(ch0_mode),
		.last(ch0_last), .word(ch0_word), .dp_ack(dp_ack0),
		.result(result), .result_valid(result_valid),
		.ack(ch0_ack), .res_valid(ch0_res_valid), .res(ch0_res), .dp_req(dp_req0),
		.op_valid(op_valid0), .mul_src(mul_src0), .add_src(add_src0),
		.multiplicand(multiplicand0), .multiplier(multiplier0), .addend(addend0)
	);

	mac_channel_ctrl ch1 (
		.clk(clk), .reset(reset), .req(ch1_req), .mode(ch1_mode),
		.last(ch1_last), .word(ch1_word), .dp_ack(dp_ack1),
		.result(result), .result_valid(result_valid),
		.ack(ch1_ack), .res_valid(ch1_res_valid), .res(ch1_res), .dp_req(dp_req1),
		.op_valid(op_valid1), .mul_src(mul_src1), .add_src(add_src1),
		.multiplicand(multiplicand1), .multiplier(multiplier1), .addend(addend1)
	);

	mac_arbiter arb (
		.clk(clk), .reset(reset), .dp_req0(dp_req0), .dp_req1(dp_req1),
		.op_valid0(op_valid0), .mul_src0(mul_src0), .add_src0(add_src0),
		.multiplicand0(multiplicand0), .multiplier0(multiplier0), .addend0(addend0),
		.op_valid1(op_valid1), .mul_src1(mul_src1), .add_src1(add_src1),
		.multiplicand1(multiplicand1), .multiplier1(multiplier1), .addend1(addend1),
		.dp_ack0(dp_ack0), .dp_ack1(dp_ack1),
		.op_valid(dp_op_valid), .mul_src(dp_mul_src), .add_src(dp_add_src),
		.multiplicand(dp_multiplicand), .multiplier(dp_multiplier), .addend(dp_addend)
	);

	mac_datapath dp (
		.clk(clk), .reset(reset), .op_valid(dp_op_valid),
		.mul_src(dp_mul_src), .add_src(dp_add_src),
		.multiplicand(dp_multiplicand), .multiplier(dp_multiplier), .addend(dp_addend),
		.result(result), .result_valid(result_valid)
	);

endmodule

// ==== rtl/mac_cmd_pkg.sv ====
`include "mac_params.svh"

package mac_cmd_pkg;

	// Picks which view of the command word the channel controller decodes
	typedef enum logic {
		MODE_SOP = 1'b0,
		MODE_TRI = 1'b1
	} mac_mode_e;

	// One command word from the host, read according to mac_mode_e
	typedef union packed {
		// Trinomial view holds all operands of (a*x + b)*x + c
		// The x field shares its bits with the x field of the other view
		struct packed {
			logic [`MAC_OPERAND_W-1:0] a;
			logic [`MAC_OPERAND_W-1:0] b;
			logic [`MAC_OPERAND_W-1:0] c;
			logic [`MAC_OPERAND_W-1:0] x;
		} trin;
		// Sum-of-products view holds one a*x element of a burst
		// Upper bits are reserved and ignored by the controller
		struct packed {
			logic [`MAC_CMD_W-2*`MAC_OPERAND_W-1:0] rsvd;
			logic [`MAC_OPERAND_W-1:0] a;
			logic [`MAC_OPERAND_W-1:0] x;
		} sop;
	} mac_cmd_u;

endpackage

// ==== rtl/mac_datapath.sv ====
`timescale 1ns/10ps
`include "mac_params.svh"

module mac_datapath
	import mac_dp_pkg::*;
(
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      op_valid,
	input  mul_src_e                  mul_src,
	input  add_src_e                  add_src,
	input  logic [`MAC_OPERAND_W-1:0] multiplicand,
	input  logic [`MAC_OPERAND_W-1:0] multiplier,
	input  logic [`MAC_OPERAND_W-1:0] addend,
	output logic [`MAC_RESULT_W-1:0]  result,
	output logic                      result_valid
);

	// One valid bit per pipeline stage, the oldest one at the top
	logic [`MAC_PIPE_DEPTH-1:0] valid_pipe;
	logic [`MAC_RESULT_W-1:0]   mul_in;
	logic [`MAC_RESULT_W-1:0]   s1_prod;
	logic [`MAC_OPERAND_W-1:0]  s1_addend;
	add_src_e                   s1_add_src;

	// Feedback takes the result register as multiplicand
	// The product is kept modulo 2^25 like every other value here
	assign mul_in = (mul_src == MUL_SRC_RESULT) ? result : `MAC_RESULT_W'(multiplicand);

	assign result_valid = valid_pipe[`MAC_PIPE_DEPTH-1];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[`MAC_PIPE_DEPTH-2:0], op_valid};
		end
	end

	// Stage one holds the product together with what stage two must add
	always_ff @(posedge clk) begin
		if (op_valid) begin
			s1_prod <= `MAC_RESULT_W'(mul_in * multiplier);
			s1_addend <= addend;
			s1_add_src <= add_src;
		end
	end

	// Stage two updates the result register
	// Accumulation reads the value written one cycle earlier, so
	// back-to-back elements chain without a bubble
	always_ff @(posedge clk) begin
		if (valid_pipe[0]) begin
			result <= s1_prod + ((s1_add_src == ADD_SRC_ACCUM) ?
				result : `MAC_RESULT_W'(s1_addend));
		end
	end

endmodule

// ==== rtl/mac_dp_pkg.sv ====
package mac_dp_pkg;

	// Source of the multiplicand that is multiplied by the issued multiplier
	typedef enum logic {
		// Issued multiplicand from the controller
		MUL_SRC_OPERAND = 1'b0,
		// Current result register, used by the second trinomial step
		MUL_SRC_RESULT = 1'b1
	} mul_src_e;

	// Source of the term that the add stage adds to the product
	typedef enum logic {
		// Issued addend from the controller
		ADD_SRC_OPERAND = 1'b0,
		// Current result register, which makes the add stage accumulate
		ADD_SRC_ACCUM = 1'b1
	} add_src_e;

endpackage

// ==== rtl/mac_params.svh ====
`ifndef MAC_PARAMS_SVH
`define MAC_PARAMS_SVH

// Width of each operand a, b, c and x as the host supplies it
`define MAC_OPERAND_W 8

// Width of the result register, the accumulator and every host result
// A trinomial of full-scale operands needs 24 bits, so one spare bit remains
`define MAC_RESULT_W 25

// Width of one host command word
`define MAC_CMD_W 32

// Cycles from an issue on op_valid to its result_valid pulse
// The datapath has one product stage and one add stage
`define MAC_PIPE_DEPTH 2

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the cluster testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f mac_cluster.f \
	--top-module mac_cluster_tb -Mdir obj_dir -o mac_cluster_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/mac_cluster_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "TB PASSED" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi

// ==== verif/mac_cluster_assertions.sv ====
`timescale 1ns/10ps

module mac_cluster_assertions (
	input logic       clk,
	input logic       reset,
	// Requests and acknowledges of two four-phase links
	input logic [1:0] req,
	input logic [1:0] ack,
	// High where the two acknowledges are grants of one shared resource
	input logic       acks_exclusive,
	// A result strobe that must last a single cycle
	input logic       pulse,
	// Outputs that sit low while reset is applied
	input logic [3:0] quiet
);

	for (genvar i = 0; i < 2; i++) begin : g_link
		// An acknowledge only answers a request that is still up
		ack_rise_with_req: assert property (@(posedge clk) disable iff (reset)
			$rose(ack[i]) |-> req[i])
			else $error("Link %0d raised ack without a pending req", i);

		// A grant or host ack is held until its request has gone away
		ack_held_during_req: assert property (@(posedge clk) disable iff (reset)
			$fell(ack[i]) |-> !$past(req[i]))
			else $error("Link %0d dropped ack while req was still high", i);
	end

	// Only one channel owns the datapath at a time
	one_grant: assert property (@(posedge clk) disable iff (reset)
		acks_exclusive |-> !(ack[0] && ack[1]))
		else $error("Both channels hold the datapath grant");

	single_cycle_pulse: assert property (@(posedge clk) disable iff (reset)
		pulse |=> !pulse)
		else $error("Result pulse lasted more than one cycle");

	low_in_reset: assert property (@(posedge clk)
		reset |-> (ack == 2'b00) && (quiet == 4'b0000))
		else $error("An output was not low during reset");

endmodule

// ==== verif/mac_cluster_tb.sv ====
`timescale 1ns/10ps
`include "mac_params.svh"

module mac_cluster_tb
	import mac_cmd_pkg::*;
();

	logic                     clk;
	logic                     reset;
	logic [1:0]               host_req;
	logic [1:0]               host_last;
	mac_mode_e                host_mode [2];
	logic [`MAC_CMD_W-1:0]    host_word [2];
	logic [1:0]               host_ack;
	logic                     res_valid0;
	logic                     res_valid1;
	logic [`MAC_RESULT_W-1:0] res0;
	logic [`MAC_RESULT_W-1:0] res1;

	// Each command is {mode, last, word}, and each channel gets its own expected results
	logic [`MAC_CMD_W+1:0]    cmd0_q [$];
	logic [`MAC_CMD_W+1:0]    cmd1_q [$];
	logic [`MAC_RESULT_W-1:0] exp0_q [$];
	logic [`MAC_RESULT_W-1:0] exp1_q [$];
	// Running reference sum of an open burst per channel
	logic [`MAC_RESULT_W-1:0] sop_sum [2];
	logic                     burst_open [2];
	logic [31:0]              rng [2];
	int                       line_count;
	int                       checked;
	int                       mismatches;
	int                       other_errors;
	logic                     load_done;

	mac_cluster_top dut0 (
		.clk(clk), .reset(reset),
		.ch0_req(host_req[0]), .ch0_mode(host_mode[0]), .ch0_last(host_last[0]),
		.ch0_word(host_word[0]), .ch0_ack(host_ack[0]),
		.ch0_res_valid(res_valid0), .ch0_res(res0),
		.ch1_req(host_req[1]), .ch1_mode(host_mode[1]), .ch1_last(host_last[1]),
		.ch1_word(host_word[1]), .ch1_ack(host_ack[1]),
		.ch1_res_valid(res_valid1), .ch1_res(res1)
	);

	// The arbiter's acks are grants of the one datapath
	bind mac_arbiter mac_cluster_assertions arb_checks (
		.clk(clk), .reset(reset), .req({dp_req1, dp_req0}), .ack({dp_ack1, dp_ack0}),
		.acks_exclusive(1'b1), .pulse(1'b0), .quiet({3'b000, op_valid})
	);

	// Host link and datapath link of every channel controller
	bind mac_channel_ctrl mac_cluster_assertions ctrl_checks (
		.clk(clk), .reset(reset), .req({dp_req, req}), .ack({dp_ack, ack}),
		.acks_exclusive(1'b0), .pulse(res_valid),
		.quiet({res_valid, op_valid, dp_req, result_valid})
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Plain unsigned arithmetic of a*x, kept to the result width
	function automatic logic [`MAC_RESULT_W-1:0] product_ref(
		input logic [`MAC_OPERAND_W-1:0] a, input logic [`MAC_OPERAND_W-1:0] x);
		logic [31:0] p;
		p = 32'(a) * 32'(x);
		return p[`MAC_RESULT_W-1:0];
	endfunction

	// Trinomial fields sit as a, b, c, x from the top byte down
	function automatic logic [`MAC_RESULT_W-1:0] trinomial_ref(input logic [31:0] w);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] x;
		logic [31:0] v;
		a = 32'(w[31:24]);
		b = 32'(w[23:16]);
		c = 32'(w[15:8]);
		x = 32'(w[7:0]);
		v = (a * x + b) * x + c;
		return v[`MAC_RESULT_W-1:0];
	endfunction

	// Reads the command stream and cross-checks each expected value against the arithmetic
	task automatic load_testdata();
		int                       fd;
		int                       n;
		int                       ch;
		int                       md;
		int                       lst;
		logic [31:0]              w;
		logic [31:0]              e;
		logic [`MAC_RESULT_W-1:0] ref_val;
		string                    line;
		fd = $fopen("verif/mac_cluster_testdata.txt", "r");
		if (fd == 0) begin
			$display("Could not open verif/mac_cluster_testdata.txt");
			other_errors++;
			return;
		end
		while (!$feof(fd)) begin
			if ($fgets(line, fd) == 0)
				break;
			// Comment and blank lines do not scan as five fields
			n = $sscanf(line, "%d %d %d %h %h", ch, md, lst, w, e);
			if (n == 5 && (ch == 0 || ch == 1)) begin
				line_count++;
				if (md[0]) begin
					ref_val = trinomial_ref(w);
				end else begin
					if (!burst_open[ch])
						sop_sum[ch] = '0;
					sop_sum[ch] = sop_sum[ch] + product_ref(w[15:8], w[7:0]);
					burst_open[ch] = !lst[0];
					ref_val = sop_sum[ch];
				end
				// Only a trinomial or the last element of a burst gives a result
				if (md[0] || lst[0]) begin
					if (e[`MAC_RESULT_W-1:0] != ref_val) begin
						$display("Data line %0d expects %0h but the arithmetic gives %0h",
							line_count, e[`MAC_RESULT_W-1:0], ref_val);
						other_errors++;
					end
					if (ch == 0)
						exp0_q.push_back(e[`MAC_RESULT_W-1:0]);
					else
						exp1_q.push_back(e[`MAC_RESULT_W-1:0]);
				end
				if (ch == 0)
					cmd0_q.push_back({md[0], lst[0], w});
				else
					cmd1_q.push_back({md[0], lst[0], w});
			end
		end
		$fclose(fd);
	endtask

	// Four-phase host side, with inputs changing 1 ns after the rising edge
	task automatic drive_channel(input int ch);
		logic [`MAC_CMD_W+1:0] cmd;
		int                    n;
		int                    gap;
		n = (ch == 0) ? cmd0_q.size() : cmd1_q.size();
		for (int i = 0; i < n; i++) begin
			cmd = (ch == 0) ? cmd0_q[i] : cmd1_q[i];
			rng[ch] = lcg_next(rng[ch]);
			gap = 32'(rng[ch][17:16]);
			repeat (gap) @(posedge clk);
			@(posedge clk);
			#1;
			host_mode[ch] = cmd[`MAC_CMD_W+1] ? MODE_TRI : MODE_SOP;
			host_last[ch] = cmd[`MAC_CMD_W];
			host_word[ch] = cmd[`MAC_CMD_W-1:0];
			host_req[ch] = 1'b1;
			// Ack is looked at mid-cycle where it is settled
			do
				@(negedge clk);
			while (!host_ack[ch]);
			// The issue is taken at the next edge, so req stays up until then
			@(posedge clk);
			#1;
			host_req[ch] = 1'b0;
			do
				@(negedge clk);
			while (host_ack[ch]);
		end
	endtask

	task automatic check_result(input int ch, input logic [`MAC_RESULT_W-1:0] got);
		logic [`MAC_RESULT_W-1:0] exp;
		int                       avail;
		avail = (ch == 0) ? exp0_q.size() : exp1_q.size();
		if (avail == 0) begin
			$display("Channel %0d gave result %0h at %0t ns when no result was due",
				ch, got, $time);
			other_errors++;
		end else begin
			if (ch == 0)
				exp = exp0_q.pop_front();
			else
				exp = exp1_q.pop_front();
			checked++;
			if (got != exp) begin
				$display("** Error at %0t ns: channel %0d result %0h, expected %0h",
					$time, ch, got, exp);
				mismatches++;
			end
		end
	endtask

	// Results are one-cycle pulses, so each is taken at the falling edge
	always @(negedge clk) begin
		if (!reset) begin
			if (res_valid0)
				check_result(0, res0);
			if (res_valid1)
				check_result(1, res1);
		end
	end

	initial begin
		reset = 1'b1;
		host_req = 2'b00;
		host_last = 2'b00;
		host_mode[0] = MODE_SOP;
		host_mode[1] = MODE_SOP;
		host_word[0] = '0;
		host_word[1] = '0;
		sop_sum[0] = '0;
		sop_sum[1] = '0;
		burst_open[0] = 1'b0;
		burst_open[1] = 1'b0;
		rng[0] = 32'h1f4e;
		// Channel 1 runs one step ahead so the two channels get different gaps
		rng[1] = lcg_next(32'h1f4e);
		line_count = 0;
		checked = 0;
		mismatches = 0;
		other_errors = 0;
		load_done = 1'b0;
		load_testdata();
		if (line_count == 0) begin
			$display("The test data file held no commands");
			other_errors++;
		end else begin
			load_done = 1'b1;
		end
		repeat (3) @(posedge clk);
		#1;
		reset = 1'b0;
		fork
			drive_channel(0);
			drive_channel(1);
		join
		// A trinomial result can still be in flight after its ack
		for (int i = 0; i < 100; i++) begin
			if (exp0_q.size() == 0 && exp1_q.size() == 0)
				break;
			@(posedge clk);
		end
		// A few more cycles let a spurious extra pulse show up
		repeat (8) @(posedge clk);
		if (exp0_q.size() != 0 || exp1_q.size() != 0) begin
			$display("Results never arrived: channel 0 missed %0d, channel 1 missed %0d",
				exp0_q.size(), exp1_q.size());
			other_errors += exp0_q.size() + exp1_q.size();
		end
		$display("Results checked %0d, mismatches %0d, other errors %0d",
			checked, mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// Each command line gets 400 ns of budget
	initial begin
		wait (load_done);
		#(line_count * 400);
		$display("Timeout: the run did not end within %0d ns", line_count * 400);
		$display("TB FAILED");
		$finish;
	end

endmodule

// ==== verif/mac_cluster_testdata.txt ====
# channel mode(0 sum-of-products, 1 trinomial) last word(hex) expected(hex)
# expected is checked on trinomial lines and on lines with last set, 0 elsewhere
0 1 0 01020304 000001b
1 0 0 00000203 0000000
1 0 0 00000405 0000000
0 1 0 ffffffff 0fe01ff
1 0 0 00000607 0000000
1 0 1 00000809 000008c
0 0 0 00000305 0000000
0 0 0 00000a14 0000000
0 0 1 00000707 0000108
1 1 0 00000509 0000005
0 0 1 00001234 00003a8
1 1 0 0203040a 00000ea
0 0 1 abcd1234 00003a8
1 0 1 0000ffff 000fe01
0 1 0 10203002 00000b0
1 0 0 0000ffff 0000000
1 0 0 0000ffff 0000000
0 1 0 80000103 0000481
1 0 1 00000101 001fc03
1 1 1 05060708 0000177
